//--- Makefile
# Verilator simulation of chip_top with its testbench

VERILATOR ?= verilator
TOP       ?= tb_chip_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
logic/chip_pkg.sv
logic/link_if.sv
logic/tag_master.sv
logic/tag_client.sv
logic/repeater_buffer.sv
logic/repeater_node.sv
logic/chip_top.sv
testbench/chip_properties.sv
testbench/tb_chip_top.sv

//--- logic/chip_pkg.sv
package chip_pkg;

  ////////////////////////////////////////
  // Link flits

  localparam int FLIT_W = 16;
  typedef logic [FLIT_W-1:0] flit_t;

  localparam int DID_W = 4;
  typedef logic [DID_W-1:0] did_t;

  ////////////////////////////////////////
  // Tag network

  localparam int TAG_NUM_CLIENTS = 2;

  localparam int TAG_ID_W = 1;
  typedef logic [TAG_ID_W-1:0] tag_id_t;

  // Payload is one reset bit on top of the did
  localparam int TAG_PAYLOAD_W = 5;
  localparam int TAG_RESET_BIT = 4;
  typedef logic [TAG_PAYLOAD_W-1:0] tag_payload_t;

  // Bit counter covers both the id and the payload fields
  localparam int TAG_CNT_W = $clog2(TAG_ID_W + TAG_PAYLOAD_W);
  typedef logic [TAG_CNT_W-1:0] tag_cnt_t;

  localparam tag_id_t CLIENT_PREV = 1'b0;
  localparam tag_id_t CLIENT_NEXT = 1'b1;

  typedef enum logic [1:0] {TAG_IDLE, TAG_ID, TAG_PAYLOAD} tag_state_e;

endpackage

//--- logic/chip_top.sv
`timescale 1ns/100ps

module chip_top
  (input  logic            clk_i
  ,input  logic            rst_n_i
  ,input  logic            tag_data_i
  ,input  logic            tag_en_i

  ,input  logic            prev_a_in_valid_i
  ,input  chip_pkg::flit_t prev_a_in_data_i
  ,output logic            prev_a_in_ready_o
  ,output logic            prev_a_out_valid_o
  ,output chip_pkg::flit_t prev_a_out_data_o
  ,input  logic            prev_a_out_ready_i
  ,input  logic            prev_b_in_valid_i
  ,input  chip_pkg::flit_t prev_b_in_data_i
  ,output logic            prev_b_in_ready_o
  ,output logic            prev_b_out_valid_o
  ,output chip_pkg::flit_t prev_b_out_data_o
  ,input  logic            prev_b_out_ready_i

  ,input  logic            next_a_in_valid_i
  ,input  chip_pkg::flit_t next_a_in_data_i
  ,output logic            next_a_in_ready_o
  ,output logic            next_a_out_valid_o
  ,output chip_pkg::flit_t next_a_out_data_o
  ,input  logic            next_a_out_ready_i
  ,input  logic            next_b_in_valid_i
  ,input  chip_pkg::flit_t next_b_in_data_i
  ,output logic            next_b_in_ready_o
  ,output logic            next_b_out_valid_o
  ,output chip_pkg::flit_t next_b_out_data_o
  ,input  logic            next_b_out_ready_i

  ,output chip_pkg::did_t  prev_did_o
  ,output chip_pkg::did_t  next_did_o
  );

  logic                                 tag_bit;
  logic [chip_pkg::TAG_NUM_CLIENTS-1:0] tag_shift;
  logic [chip_pkg::TAG_NUM_CLIENTS-1:0] tag_commit;
  logic                                 prev_reset;
  logic                                 next_reset;

  link_if prev_a_link ();
  link_if prev_b_link ();
  link_if next_a_link ();
  link_if next_b_link ();

  ////////////////////////////////////////
  // Tag network

  tag_master
    btm
      (.clk_i        ( clk_i )
      ,.rst_n_i      ( rst_n_i )
      ,.tag_data_i   ( tag_data_i )
      ,.tag_en_i     ( tag_en_i )
      ,.tag_bit_o    ( tag_bit )
      ,.tag_shift_o  ( tag_shift )
      ,.tag_commit_o ( tag_commit )
      );

  tag_client
    btc_prev
      (.clk_i        ( clk_i )
      ,.rst_n_i      ( rst_n_i )
      ,.tag_bit_i    ( tag_bit )
      ,.tag_shift_i  ( tag_shift[chip_pkg::CLIENT_PREV] )
      ,.tag_commit_i ( tag_commit[chip_pkg::CLIENT_PREV] )
      ,.node_reset_o ( prev_reset )
      ,.did_o        ( prev_did_o )
      );

  tag_client
    btc_next
      (.clk_i        ( clk_i )
      ,.rst_n_i      ( rst_n_i )
      ,.tag_bit_i    ( tag_bit )
      ,.tag_shift_i  ( tag_shift[chip_pkg::CLIENT_NEXT] )
      ,.tag_commit_i ( tag_commit[chip_pkg::CLIENT_NEXT] )
      ,.node_reset_o ( next_reset )
      ,.did_o        ( next_did_o )
      );

  ////////////////////////////////////////
  // Port mapping, side A sends fwd and side B sends rev

  assign prev_a_link.fwd_valid = prev_a_in_valid_i;
  assign prev_a_link.fwd_data  = prev_a_in_data_i;
  assign prev_a_in_ready_o     = prev_a_link.fwd_ready;
  assign prev_a_out_valid_o    = prev_a_link.rev_valid;
  assign prev_a_out_data_o     = prev_a_link.rev_data;
  assign prev_a_link.rev_ready = prev_a_out_ready_i;

  assign prev_b_link.rev_valid = prev_b_in_valid_i;
  assign prev_b_link.rev_data  = prev_b_in_data_i;
  assign prev_b_in_ready_o     = prev_b_link.rev_ready;
  assign prev_b_out_valid_o    = prev_b_link.fwd_valid;
  assign prev_b_out_data_o     = prev_b_link.fwd_data;
  assign prev_b_link.fwd_ready = prev_b_out_ready_i;

  assign next_a_link.fwd_valid = next_a_in_valid_i;
  assign next_a_link.fwd_data  = next_a_in_data_i;
  assign next_a_in_ready_o     = next_a_link.fwd_ready;
  assign next_a_out_valid_o    = next_a_link.rev_valid;
  assign next_a_out_data_o     = next_a_link.rev_data;
  assign next_a_link.rev_ready = next_a_out_ready_i;

  assign next_b_link.rev_valid = next_b_in_valid_i;
  assign next_b_link.rev_data  = next_b_in_data_i;
  assign next_b_in_ready_o     = next_b_link.rev_ready;
  assign next_b_out_valid_o    = next_b_link.fwd_valid;
  assign next_b_out_data_o     = next_b_link.fwd_data;
  assign next_b_link.fwd_ready = next_b_out_ready_i;

  ////////////////////////////////////////
  // Repeater nodes

  repeater_node
    prev_node
      (.clk_i        ( clk_i )
      ,.rst_n_i      ( rst_n_i )
      ,.node_reset_i ( prev_reset )
      ,.side_a       ( prev_a_link.side_b )
      ,.side_b       ( prev_b_link.side_a )
      );

  repeater_node
    next_node
      (.clk_i        ( clk_i )
      ,.rst_n_i      ( rst_n_i )
      ,.node_reset_i ( next_reset )
      ,.side_a       ( next_a_link.side_b )
      ,.side_b       ( next_b_link.side_a )
      );

endmodule

//--- logic/link_if.sv
`timescale 1ns/100ps

// One channel in each direction, fwd runs A to B and rev runs B to A
interface link_if;
  logic            fwd_valid;
  chip_pkg::flit_t fwd_data;
  logic            fwd_ready;
  logic            rev_valid;
  chip_pkg::flit_t rev_data;
  logic            rev_ready;

  modport side_a
    (output fwd_valid
    ,output fwd_data
    ,input  fwd_ready
    ,input  rev_valid
    ,input  rev_data
    ,output rev_ready
    );

  modport side_b
    (input  fwd_valid
    ,input  fwd_data
    ,output fwd_ready
    ,output rev_valid
    ,output rev_data
    ,input  rev_ready
    );

endinterface

//--- logic/repeater_buffer.sv
`timescale 1ns/100ps

module repeater_buffer
  #(parameter int WIDTH = chip_pkg::FLIT_W)
  (input  logic             clk_i
  ,input  logic             rst_n_i
  ,input  logic             clear_i
  ,input  logic             in_valid_i
  ,input  logic [WIDTH-1:0] in_data_i
  ,output logic             in_ready_o
  ,output logic             out_valid_o
  ,output logic [WIDTH-1:0] out_data_o
  ,input  logic             out_ready_i
  );

  logic             head_valid_r;
  logic             skid_valid_r;
  logic             ready_r;
  logic [WIDTH-1:0] head_data_r;
  logic [WIDTH-1:0] skid_data_r;
  logic             in_fire;
  logic             head_free;
  logic             head_valid_next;
  logic             skid_valid_next;

  assign in_fire   = in_valid_i & ready_r;
  assign head_free = ~head_valid_r | out_ready_i;

  // Skid slot only fills while the head is held
  always_comb
  begin
    head_valid_next = head_valid_r;
    skid_valid_next = skid_valid_r;
    if (head_free)
    begin
      head_valid_next = skid_valid_r | in_fire;
      skid_valid_next = skid_valid_r & in_fire;
    end
    else if (in_fire)
      skid_valid_next = 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || clear_i)
    begin
      head_valid_r <= 1'b0;
      skid_valid_r <= 1'b0;
      ready_r      <= 1'b0;
    end
    else
    begin
      head_valid_r <= head_valid_next;
      skid_valid_r <= skid_valid_next;
      ready_r      <= ~skid_valid_next;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (head_free)
      head_data_r <= skid_valid_r ? skid_data_r : in_data_i;
    if (in_fire && (skid_valid_r || !head_free))
      skid_data_r <= in_data_i;
  end

  assign in_ready_o  = ready_r;
  assign out_valid_o = head_valid_r;
  assign out_data_o  = head_data_r;

endmodule

//--- logic/repeater_node.sv
`timescale 1ns/100ps

module repeater_node
  (input  logic  clk_i
  ,input  logic  rst_n_i
  ,input  logic  node_reset_i
  ,link_if.side_b side_a
  ,link_if.side_a side_b
  );

  logic fwd_in_ready;
  logic fwd_out_valid;
  logic rev_in_ready;
  logic rev_out_valid;

  ////////////////////////////////////////
  // A to B

  repeater_buffer #(.WIDTH( chip_pkg::FLIT_W ))
    fwd_buf
      (.clk_i       ( clk_i )
      ,.rst_n_i     ( rst_n_i )
      ,.clear_i     ( node_reset_i )
      ,.in_valid_i  ( side_a.fwd_valid )
      ,.in_data_i   ( side_a.fwd_data )
      ,.in_ready_o  ( fwd_in_ready )
      ,.out_valid_o ( fwd_out_valid )
      ,.out_data_o  ( side_b.fwd_data )
      ,.out_ready_i ( side_b.fwd_ready )
      );

  ////////////////////////////////////////
  // B to A

  repeater_buffer #(.WIDTH( chip_pkg::FLIT_W ))
    rev_buf
      (.clk_i       ( clk_i )
      ,.rst_n_i     ( rst_n_i )
      ,.clear_i     ( node_reset_i )
      ,.in_valid_i  ( side_b.rev_valid )
      ,.in_data_i   ( side_b.rev_data )
      ,.in_ready_o  ( rev_in_ready )
      ,.out_valid_o ( rev_out_valid )
      ,.out_data_o  ( side_a.rev_data )
      ,.out_ready_i ( side_a.rev_ready )
      );

  // Node in reset shows nothing to either neighbour
  assign side_a.fwd_ready = fwd_in_ready & ~node_reset_i;
  assign side_b.fwd_valid = fwd_out_valid & ~node_reset_i;
  assign side_b.rev_ready = rev_in_ready & ~node_reset_i;
  assign side_a.rev_valid = rev_out_valid & ~node_reset_i;

endmodule

//--- logic/tag_client.sv
`timescale 1ns/100ps

module tag_client
  (input  logic            clk_i
  ,input  logic            rst_n_i
  ,input  logic            tag_bit_i
  ,input  logic            tag_shift_i
  ,input  logic            tag_commit_i
  ,output logic            node_reset_o
  ,output chip_pkg::did_t  did_o
  );

  chip_pkg::tag_payload_t shadow_r;
  chip_pkg::tag_payload_t shadow_next;
  chip_pkg::tag_payload_t cfg_r;

  // Payload shifts in LSB first
  assign shadow_next = chip_pkg::tag_payload_t'({tag_bit_i, shadow_r} >> 1);

  always_ff @(posedge clk_i)
  begin
    if (tag_shift_i)
      shadow_r <= shadow_next;
  end

  // Cold chip keeps its node in reset until configured
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      cfg_r <= chip_pkg::tag_payload_t'(1) << chip_pkg::TAG_RESET_BIT;
    else if (tag_commit_i)
      cfg_r <= shadow_next;
  end

  assign node_reset_o = cfg_r[chip_pkg::TAG_RESET_BIT];
  assign did_o        = cfg_r[chip_pkg::DID_W-1:0];

endmodule

//--- logic/tag_master.sv
`timescale 1ns/100ps

module tag_master
  (input  logic                                 clk_i
  ,input  logic                                 rst_n_i
  ,input  logic                                 tag_data_i
  ,input  logic                                 tag_en_i
  ,output logic                                 tag_bit_o
  ,output logic [chip_pkg::TAG_NUM_CLIENTS-1:0] tag_shift_o
  ,output logic [chip_pkg::TAG_NUM_CLIENTS-1:0] tag_commit_o
  );

  chip_pkg::tag_state_e state_r;
  chip_pkg::tag_cnt_t   cnt_r;
  chip_pkg::tag_id_t    id_r;
  logic                 id_last;
  logic                 payload_last;

  assign id_last      = (cnt_r == chip_pkg::tag_cnt_t'(chip_pkg::TAG_ID_W - 1));
  assign payload_last = (cnt_r == chip_pkg::tag_cnt_t'(chip_pkg::TAG_PAYLOAD_W - 1));

  ////////////////////////////////////////
  // Frame decoder

  // Bits with tag_en_i low are ignored and the FSM holds
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= chip_pkg::TAG_IDLE;
      cnt_r   <= '0;
    end
    else if (tag_en_i)
    begin
      case (state_r)
        chip_pkg::TAG_IDLE:
        begin
          cnt_r <= '0;
          if (tag_data_i)
            state_r <= chip_pkg::TAG_ID;
        end
        chip_pkg::TAG_ID:
        begin
          cnt_r <= id_last ? '0 : cnt_r + 1'b1;
          if (id_last)
            state_r <= chip_pkg::TAG_PAYLOAD;
        end
        chip_pkg::TAG_PAYLOAD:
        begin
          cnt_r <= payload_last ? '0 : cnt_r + 1'b1;
          if (payload_last)
            state_r <= chip_pkg::TAG_IDLE;
        end
        default:
          state_r <= chip_pkg::TAG_IDLE;
      endcase
    end
  end

  // Id arrives LSB first
  always_ff @(posedge clk_i)
  begin
    if (tag_en_i && state_r == chip_pkg::TAG_ID)
      id_r <= chip_pkg::tag_id_t'({tag_data_i, id_r} >> 1);
  end

  ////////////////////////////////////////
  // Client tag lines

  assign tag_bit_o = tag_data_i;

  always_comb
  begin
    tag_shift_o  = '0;
    tag_commit_o = '0;
    for (int i = 0; i < chip_pkg::TAG_NUM_CLIENTS; i++)
    begin
      if (tag_en_i && state_r == chip_pkg::TAG_PAYLOAD && id_r == chip_pkg::tag_id_t'(i))
      begin
        tag_shift_o[i]  = 1'b1;
        tag_commit_o[i] = payload_last;
      end
    end
  end

endmodule

//--- testbench/chip_properties.sv
`timescale 1ns/100ps

// Handshake rules for one link output of chip_top
module chip_properties
  (input logic            clk_i
  ,input logic            rst_n_i
  ,input logic            node_reset_i
  ,input logic            valid_i
  ,input logic            ready_i
  ,input chip_pkg::flit_t data_i
  );

  int err_cnt = 0;

  // An offered flit waits until taken, unless the node drops into reset
  hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i && !ready_i |=> node_reset_i || (valid_i && $stable(data_i)))
  else
  begin
    $error("Output flit changed or vanished while ready was low");
    err_cnt++;
  end

  // Node reset empties the buffers, nothing is offered on the first cycle after it
  quiet_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    node_reset_i |=> !valid_i)
  else
  begin
    $error("Output valid high during or right after node reset");
    err_cnt++;
  end

endmodule

bind chip_top chip_properties prev_a_chk
  (.clk_i ( clk_i ), .rst_n_i ( rst_n_i ), .node_reset_i ( prev_reset )
  ,.valid_i ( prev_a_out_valid_o ), .ready_i ( prev_a_out_ready_i )
  ,.data_i ( prev_a_out_data_o ));

bind chip_top chip_properties prev_b_chk
  (.clk_i ( clk_i ), .rst_n_i ( rst_n_i ), .node_reset_i ( prev_reset )
  ,.valid_i ( prev_b_out_valid_o ), .ready_i ( prev_b_out_ready_i )
  ,.data_i ( prev_b_out_data_o ));

bind chip_top chip_properties next_a_chk
  (.clk_i ( clk_i ), .rst_n_i ( rst_n_i ), .node_reset_i ( next_reset )
  ,.valid_i ( next_a_out_valid_o ), .ready_i ( next_a_out_ready_i )
  ,.data_i ( next_a_out_data_o ));

bind chip_top chip_properties next_b_chk
  (.clk_i ( clk_i ), .rst_n_i ( rst_n_i ), .node_reset_i ( next_reset )
  ,.valid_i ( next_b_out_valid_o ), .ready_i ( next_b_out_ready_i )
  ,.data_i ( next_b_out_data_o ));

//--- testbench/tb_chip_top.sv
`timescale 1ns/100ps

module tb_chip_top;

  localparam int PERIOD_NS       = 20;
  localparam int RESET_CYCLES    = 10;
  localparam int NUM_STEPS       = 13;
  localparam int MAX_BURST       = 16;
  localparam int MAX_STEP_CYCLES = 32 * (MAX_BURST + 2);
  localparam int TIMEOUT_NS      =
    (RESET_CYCLES + NUM_STEPS * MAX_STEP_CYCLES + 100) * PERIOD_NS;
  localparam int FRAME_LEN       = 1 + chip_pkg::TAG_ID_W + chip_pkg::TAG_PAYLOAD_W;

  // Frames use target, rst_bit, did, en. Bursts use target, dir, count, hold
  typedef struct packed {
    logic       frame;
    logic       target;
    logic       rst_bit;
    logic [3:0] did;
    logic       en;
    logic       dir;
    logic [4:0] count;
    logic       hold;
    logic [3:0] exp_prev_did;
    logic [3:0] exp_next_did;
    logic [1:0] exp_on;
  } step_t;

  // frame target rst did en dir count hold | prev_did next_did on
  localparam step_t STEPS [NUM_STEPS] = '{
    '{1'b1, 1'b0, 1'b0, 4'h5, 1'b1, 1'b0, 5'd0,  1'b0, 4'h5, 4'h0, 2'b01},
    '{1'b0, 1'b0, 1'b0, 4'h0, 1'b0, 1'b0, 5'd12, 1'b0, 4'h5, 4'h0, 2'b01},
    '{1'b0, 1'b0, 1'b0, 4'h0, 1'b0, 1'b1, 5'd12, 1'b0, 4'h5, 4'h0, 2'b01},
    '{1'b1, 1'b1, 1'b0, 4'hA, 1'b1, 1'b0, 5'd0,  1'b0, 4'h5, 4'hA, 2'b11},
    '{1'b0, 1'b1, 1'b0, 4'h0, 1'b0, 1'b0, 5'd12, 1'b0, 4'h5, 4'hA, 2'b11},
    '{1'b0, 1'b1, 1'b0, 4'h0, 1'b0, 1'b1, 5'd12, 1'b0, 4'h5, 4'hA, 2'b11},
    '{1'b1, 1'b0, 1'b1, 4'h3, 1'b0, 1'b0, 5'd0,  1'b0, 4'h5, 4'hA, 2'b11},
    '{1'b0, 1'b0, 1'b0, 4'h0, 1'b0, 1'b0, 5'd6,  1'b0, 4'h5, 4'hA, 2'b11},
    '{1'b0, 1'b0, 1'b0, 4'h0, 1'b0, 1'b0, 5'd2,  1'b1, 4'h5, 4'hA, 2'b11},
    '{1'b1, 1'b0, 1'b1, 4'hC, 1'b1, 1'b0, 5'd0,  1'b0, 4'hC, 4'hA, 2'b10},
    '{1'b1, 1'b0, 1'b0, 4'h7, 1'b1, 1'b0, 5'd0,  1'b0, 4'h7, 4'hA, 2'b11},
    '{1'b0, 1'b0, 1'b0, 4'h0, 1'b0, 1'b0, 5'd10, 1'b0, 4'h7, 4'hA, 2'b11},
    '{1'b0, 1'b0, 1'b0, 4'h0, 1'b0, 1'b1, 5'd10, 1'b0, 4'h7, 4'hA, 2'b11}
  };

  logic            clk = 1'b0;
  logic            rst_n;
  logic            tag_data;
  logic            tag_en;
  // Channel 0 is prev A to B, 1 prev B to A, 2 next A to B and 3 next B to A
  logic [3:0]      in_valid;
  logic [3:0]      in_ready;
  logic [3:0]      out_valid;
  logic [3:0]      out_ready;
  chip_pkg::flit_t in_data [4];
  chip_pkg::flit_t out_data [4];
  chip_pkg::did_t  prev_did;
  chip_pkg::did_t  next_did;
  chip_pkg::flit_t exp_q [4][$];
  logic [31:0]     rng;

  string in_rdy_name [4] = '{"prev_a_in_ready_o", "prev_b_in_ready_o",
                             "next_a_in_ready_o", "next_b_in_ready_o"};
  string out_vld_name [4] = '{"prev_b_out_valid_o", "prev_a_out_valid_o",
                              "next_b_out_valid_o", "next_a_out_valid_o"};
  string out_dat_name [4] = '{"prev_b_out_data_o", "prev_a_out_data_o",
                              "next_b_out_data_o", "next_a_out_data_o"};

  always #(PERIOD_NS / 2) clk = ~clk;

  chip_top UUT
    (.clk_i              ( clk )
    ,.rst_n_i            ( rst_n )
    ,.tag_data_i         ( tag_data )
    ,.tag_en_i           ( tag_en )
    ,.prev_a_in_valid_i  ( in_valid[0] )
    ,.prev_a_in_data_i   ( in_data[0] )
    ,.prev_a_in_ready_o  ( in_ready[0] )
    ,.prev_a_out_valid_o ( out_valid[1] )
    ,.prev_a_out_data_o  ( out_data[1] )
    ,.prev_a_out_ready_i ( out_ready[1] )
    ,.prev_b_in_valid_i  ( in_valid[1] )
    ,.prev_b_in_data_i   ( in_data[1] )
    ,.prev_b_in_ready_o  ( in_ready[1] )
    ,.prev_b_out_valid_o ( out_valid[0] )
    ,.prev_b_out_data_o  ( out_data[0] )
    ,.prev_b_out_ready_i ( out_ready[0] )
    ,.next_a_in_valid_i  ( in_valid[2] )
    ,.next_a_in_data_i   ( in_data[2] )
    ,.next_a_in_ready_o  ( in_ready[2] )
    ,.next_a_out_valid_o ( out_valid[3] )
    ,.next_a_out_data_o  ( out_data[3] )
    ,.next_a_out_ready_i ( out_ready[3] )
    ,.next_b_in_valid_i  ( in_valid[3] )
    ,.next_b_in_data_i   ( in_data[3] )
    ,.next_b_in_ready_o  ( in_ready[3] )
    ,.next_b_out_valid_o ( out_valid[2] )
    ,.next_b_out_data_o  ( out_data[2] )
    ,.next_b_out_ready_i ( out_ready[2] )
    ,.prev_did_o         ( prev_did )
    ,.next_did_o         ( next_did )
    );

  ////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    begin
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
    end
  endfunction

  task automatic abort_run;
    begin
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    begin
      assert (got == exp)
      else
      begin
        $display("MISMATCH %s exp %h got %h", name, exp, got);
        abort_run();
      end
    end
  endtask

  // Node in reset shows low ready and a running node with empty buffers shows high ready
  task automatic check_node(input int n, input logic on);
    begin
      for (int d = 0; d < 2; d++)
      begin
        check_value(in_rdy_name[2*n+d], 16'(in_ready[2*n+d]), 16'(on));
        check_value(out_vld_name[2*n+d], 16'(out_valid[2*n+d]), 16'h0);
      end
    end
  endtask

  // Start bit, client id, then payload with the did below the reset bit, all LSB first
  task automatic send_frame(input logic client, input logic rst_bit,
                            input logic [3:0] did, input logic en);
    logic [FRAME_LEN-1:0] bits;
    begin
      bits = {rst_bit, did, client, 1'b1};
      for (int i = 0; i < FRAME_LEN; i++)
      begin
        tag_en   = en;
        tag_data = bits[i];
        @(posedge clk);
        #1;
      end
      tag_en   = 1'b0;
      tag_data = 1'b0;
    end
  endtask

  task automatic run_burst(input int c, input int count, input logic hold);
    logic [31:0] ready_pat;
    logic        fire;
    int          sent;
    int          cyc;
    begin
      rng       = xorshift32(rng);
      ready_pat = rng | 32'h1;
      sent      = 0;
      cyc       = 0;
      rng       = xorshift32(rng);
      in_data[c]  = rng[15:0];
      in_valid[c] = 1'b1;
      while (sent < count)
      begin
        out_ready[c] = hold ? 1'b0 : ready_pat[cyc % 32];
        @(negedge clk);
        fire = in_ready[c];
        if (fire)
        begin
          exp_q[c].push_back(in_data[c]);
          sent++;
        end
        @(posedge clk);
        #1;
        cyc++;
        if (fire && sent < count)
        begin
          rng        = xorshift32(rng);
          in_data[c] = rng[15:0];
        end
      end
      in_valid[c] = 1'b0;
      // Two held flits fill the buffer
      if (hold)
        check_value(in_rdy_name[c], 16'(in_ready[c]), 16'h0);
      while (!hold && exp_q[c].size() != 0)
      begin
        out_ready[c] = ready_pat[cyc % 32];
        @(posedge clk);
        #1;
        cyc++;
      end
      out_ready[c] = 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // Scoreboard

  // Valid and ready seen mid-cycle means a transfer on the next edge
  always @(negedge clk)
  begin
    chip_pkg::flit_t want;
    for (int c = 0; c < 4; c++)
    begin
      if (rst_n && out_valid[c] && out_ready[c])
      begin
        assert (exp_q[c].size() != 0)
        else
        begin
          $display("Flit %h came out on %s with none expected", out_data[c], out_dat_name[c]);
          abort_run();
        end
        want = exp_q[c].pop_front();
        check_value(out_dat_name[c], out_data[c], want);
      end
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, the test sequence did not finish", TIMEOUT_NS);
    abort_run();
  end

  ////////////////////////////////////////
  // Main sequence

  initial
  begin
    step_t step;
    rng       = 32'd91;
    rst_n     = 1'b0;
    tag_data  = 1'b0;
    tag_en    = 1'b0;
    in_valid  = '0;
    out_ready = '0;
    for (int c = 0; c < 4; c++)
      in_data[c] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check_node(0, 1'b0);
    check_node(1, 1'b0);
    check_value("prev_did_o", 16'(prev_did), 16'h0);
    check_value("next_did_o", 16'(next_did), 16'h0);

    for (int i = 0; i < NUM_STEPS; i++)
    begin
      step = STEPS[i];
      if (step.frame)
      begin
        send_frame(step.target, step.rst_bit, step.did, step.en);
        repeat (3) @(posedge clk);
        #1;
        for (int n = 0; n < 2; n++)
        begin
          // Flits held by a node in reset are gone
          if (!step.exp_on[n])
          begin
            exp_q[2*n].delete();
            exp_q[2*n+1].delete();
          end
          check_node(n, step.exp_on[n]);
        end
      end
      else
        run_burst(int'({step.target, step.dir}), int'(step.count), step.hold);
      check_value("prev_did_o", 16'(prev_did), 16'(step.exp_prev_did));
      check_value("next_did_o", 16'(next_did), 16'(step.exp_next_did));
    end

    repeat (2) @(posedge clk);
    #1;
    // Both nodes drained with nothing left over
    check_node(0, 1'b1);
    check_node(1, 1'b1);
    if (UUT.prev_a_chk.err_cnt + UUT.prev_b_chk.err_cnt
        + UUT.next_a_chk.err_cnt + UUT.next_b_chk.err_cnt != 0)
    begin
      $display("Bound link checks reported failures");
      abort_run();
    end
    else
    begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule
